/* include/hub75_config.svh */
// hub75 panel geometry and colour depth shared by the design
`ifndef HUB75_CONFIG_SVH
`define HUB75_CONFIG_SVH

// panel size, one bank of scan rows
`define HUB75_N_ROWS 4
`define HUB75_N_COLS 8

// bitplanes per colour channel
`define HUB75_N_PLANES 4

// address widths
`define HUB75_LOG_ROWS 2   // row select on the panel address pins
`define HUB75_LOG_COLS 3   // column index into the frame buffer

// plane index width
`define HUB75_LOG_PLANES 2

`endif

/* verilog/hub75_pkg.sv */
// hub75 shared types for pixels, timing config and panel pins
`include "hub75_config.svh"

package hub75_pkg;

	// frame buffer word, plane-depth colour per channel
	typedef struct packed {
		logic [`HUB75_N_PLANES-1:0] r;
		logic [`HUB75_N_PLANES-1:0] g;
		logic [`HUB75_N_PLANES-1:0] b;
	} pixel_t;

	// scan timing, all counts in clk cycles
	typedef struct packed {
		logic [7:0] pre_latch_len;   // settle before le
		logic [7:0] latch_len;       // le pulse width
		logic [7:0] post_latch_len;  // hold after le
		logic [7:0] bit_len;         // lit time of plane 0
	} cfg_t;

	// one panel pin set
	typedef struct packed {
		logic [`HUB75_LOG_ROWS-1:0] addr;  // row select
		logic [2:0] data;                  // r, g and b serial bits
		logic clk;                         // shift clock
		logic le;                          // latch enable
		logic blank;                       // output enable, active high blanks
	} pins_t;

endpackage

/* verilog/hub75_framebuffer.sv */
// hub75 double-buffered pixel store, host writes back page, scan reads front
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_framebuffer (
	input  logic clk,
	input  logic rst,

	// host side, back page
	input  logic [`HUB75_LOG_ROWS-1:0] wr_row,
	input  logic [`HUB75_LOG_COLS-1:0] wr_col,
	input  hub75_pkg::pixel_t          wr_pixel,
	input  logic                       wr_en,

	// shifter side, front page
	input  logic [`HUB75_LOG_ROWS-1:0] rd_row,
	input  logic [`HUB75_LOG_COLS-1:0] rd_col,
	output hub75_pkg::pixel_t          rd_pixel,

	// page flip, only while scan idle
	input  logic swap
);

	import hub75_pkg::*;

	localparam int AW    = 1 + `HUB75_LOG_ROWS + `HUB75_LOG_COLS;  // page, row, col
	localparam int DEPTH = 2 * `HUB75_N_ROWS * `HUB75_N_COLS;       // two full pages

	pixel_t mem [0:DEPTH-1];

	logic          front;    // page currently scanned out
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;

	// writer always lands in the hidden page
	assign wr_addr = {~front, wr_row, wr_col};
	assign rd_addr = {front, rd_row, rd_col};

	// front page select
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			front <= 1'b0;  // page 0 shown first
		end else if (swap) begin
			front <= ~front;
		end
	end

	// storage, registered read port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_pixel;
		end
		rd_pixel <= mem[rd_addr];  // one cycle latency seen by shifter
	end

endmodule

/* verilog/hub75_ctrl.sv */
// hub75 row and bitplane sequencer for shift, latch and lit phases
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_ctrl (
	input  logic clk,
	input  logic rst,

	// scan request from top
	input  logic            go,
	output logic            rdy,   // idle, previous frame complete
	input  hub75_pkg::cfg_t cfg,

	// shifter
	output logic                         shift_go,
	output logic [`HUB75_LOG_ROWS-1:0]   shift_row,
	output logic [`HUB75_LOG_PLANES-1:0] shift_plane,
	input  logic                         shift_rdy,

	// blanking
	output logic                         blank_go,
	output logic [`HUB75_LOG_PLANES-1:0] blank_plane,
	input  logic                         blank_rdy,

	// panel pins
	output logic [`HUB75_LOG_ROWS-1:0] addr,
	output logic                       le
);

	localparam int LR = `HUB75_LOG_ROWS;
	localparam int LP = `HUB75_LOG_PLANES;
	localparam logic [LR-1:0] LAST_ROW   = LR'(`HUB75_N_ROWS - 1);
	localparam logic [LP-1:0] LAST_PLANE = LP'(`HUB75_N_PLANES - 1);

	typedef enum logic [2:0] {
		IDLE,   // waiting for go
		WAIT,   // shift and previous plane both finishing
		PRE,    // data settle before latch
		LATCH,  // le high
		POST,   // hold after latch
		DRAIN   // last plane still lit
	} state_t;

	state_t     state;
	logic [7:0] cnt;  // shared phase counter

	assign rdy = (state == IDLE);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= IDLE;
			cnt         <= '0;
			shift_go    <= 1'b0;
			shift_row   <= '0;
			shift_plane <= '0;
			blank_go    <= 1'b0;
			blank_plane <= '0;
			addr        <= '0;
			le          <= 1'b0;
		end else begin
			shift_go <= 1'b0;
			blank_go <= 1'b0;
			case (state)
			IDLE: begin
				if (go) begin
					shift_go    <= 1'b1;  // first plane of row 0
					shift_row   <= '0;
					shift_plane <= '0;
					state       <= WAIT;
				end
			end
			WAIT: begin
				// rdy levels lag the go pulse by a cycle
				if (!shift_go && shift_rdy && blank_rdy) begin
					addr        <= shift_row;    // panel dark here, safe to move
					blank_plane <= shift_plane;  // plane being latched
					cnt         <= cfg.pre_latch_len;
					state       <= PRE;
				end
			end
			PRE: begin
				if (cnt <= 8'd1) begin
					cnt   <= cfg.latch_len;
					le    <= 1'b1;
					state <= LATCH;
				end else begin
					cnt <= cnt - 8'd1;
				end
			end
			LATCH: begin
				if (cnt <= 8'd1) begin
					cnt   <= cfg.post_latch_len;
					le    <= 1'b0;
					state <= POST;
				end else begin
					cnt <= cnt - 8'd1;
				end
			end
			POST: begin
				if (cnt <= 8'd1) begin
					blank_go <= 1'b1;  // light the latched plane
					if (shift_row == LAST_ROW && shift_plane == LAST_PLANE) begin
						state <= DRAIN;
					end else begin
						shift_go <= 1'b1;  // next plane shifts while this one is lit
						if (shift_plane == LAST_PLANE) begin
							shift_plane <= '0;
							shift_row   <= shift_row + LR'(1);
						end else begin
							shift_plane <= shift_plane + LP'(1);
						end
						state <= WAIT;
					end
				end else begin
					cnt <= cnt - 8'd1;
				end
			end
			DRAIN: begin
				if (!blank_go && blank_rdy) begin
					state <= IDLE;  // frame done
				end
			end
			default: state <= IDLE;
			endcase
		end
	end

endmodule

/* verilog/hub75_shift.sv */
// hub75 column shifter, one plane of one row out on the serial data pins
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_shift (
	input  logic clk,
	input  logic rst,

	// control
	input  logic                         go,
	input  logic [`HUB75_LOG_ROWS-1:0]   row,
	input  logic [`HUB75_LOG_PLANES-1:0] plane,
	output logic                         rdy,

	// frame buffer read port
	output logic [`HUB75_LOG_ROWS-1:0] rd_row,
	output logic [`HUB75_LOG_COLS-1:0] rd_col,
	input  hub75_pkg::pixel_t          rd_pixel,

	// panel side
	output logic [2:0] data,  // r, g, b
	output logic       pclk
);

	localparam int CW = `HUB75_LOG_COLS + 2;                 // phase bit, column, tail
	localparam logic [CW-1:0] LAST = CW'(2 * `HUB75_N_COLS);  // tail step, last clock high

	logic [CW-1:0]                cnt;
	logic [`HUB75_LOG_PLANES-1:0] plane_q;

	// even step issues the read, odd step captures it
	assign rd_col = cnt[CW-2:1];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rdy  <= 1'b1;
			cnt  <= '0;
			pclk <= 1'b0;
		end else begin
			pclk <= 1'b0;  // high for one cycle per column
			if (go) begin
				rdy <= 1'b0;
				cnt <= '0;
			end else if (!rdy) begin
				cnt <= cnt + CW'(1);
				if (!cnt[0] && cnt != '0) begin
					pclk <= 1'b1;  // clock in the column set up last step
				end
				if (cnt == LAST) begin
					rdy <= 1'b1;
				end
			end
		end
	end

	// row and plane held for the whole pass
	always_ff @(posedge clk) begin
		if (go) begin
			rd_row  <= row;
			plane_q <= plane;
		end
		if (!rdy && cnt[0]) begin
			data <= {rd_pixel.r[plane_q], rd_pixel.g[plane_q], rd_pixel.b[plane_q]};
		end
	end

endmodule

/* verilog/hub75_blanking.sv */
// hub75 lit interval timer, binary weighted on the plane index
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_blanking (
	input  logic clk,
	input  logic rst,

	// control
	input  logic                         go,
	input  logic [`HUB75_LOG_PLANES-1:0] plane,
	input  logic [7:0]                   bit_len,  // plane 0 lit cycles
	output logic                         rdy,

	// panel side
	output logic blank
);

	localparam int CW = 8 + `HUB75_N_PLANES - 1;  // room for bit_len << top plane

	logic [CW-1:0] cnt;  // lit cycles left

	// free again the cycle the panel goes dark
	assign rdy = blank;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt   <= '0;
			blank <= 1'b1;  // dark out of reset
		end else if (go) begin
			cnt   <= CW'(bit_len) << plane;
			blank <= 1'b0;
		end else if (!blank) begin
			if (cnt <= CW'(1)) begin
				blank <= 1'b1;  // interval over
			end else begin
				cnt <= cnt - CW'(1);
			end
		end
	end

endmodule

/* verilog/hub75_phy.sv */
// hub75 pad register stage, panel held dark in reset
`timescale 1ns/1ps

module hub75_phy (
	input  logic clk,
	input  logic rst,

	// pins from the core
	input  hub75_pkg::pins_t pins_in,

	// registered pads
	output hub75_pkg::pins_t pins_out
);

	// every pin gets the same single cycle of delay
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pins_out.addr  <= '0;
			pins_out.data  <= '0;
			pins_out.clk   <= 1'b0;  // no shift edges
			pins_out.le    <= 1'b0;  // no latch
			pins_out.blank <= 1'b1;  // leds off
		end else begin
			pins_out.addr  <= pins_in.addr;
			pins_out.data  <= pins_in.data;
			pins_out.clk   <= pins_in.clk;
			pins_out.le    <= pins_in.le;
			pins_out.blank <= pins_in.blank;
		end
	end

endmodule

/* verilog/hub75_top.sv */
// hub75 panel driver top, frame buffer, sequencer, shifter, blanking and pads
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_top (
	input  logic clk,
	input  logic rst,

	// host pixel write into back page
	input  logic [`HUB75_LOG_ROWS-1:0] wr_row,
	input  logic [`HUB75_LOG_COLS-1:0] wr_col,
	input  hub75_pkg::pixel_t          wr_pixel,
	input  logic                       wr_en,

	// page swap and run control
	input  logic frame_swap,  // one-cycle request
	output logic frame_rdy,   // low while a swap is pending
	input  logic ctrl_run,

	input  hub75_pkg::cfg_t cfg,

	// panel pads
	output hub75_pkg::pins_t pins
);

	import hub75_pkg::*;

	logic swap_pending;
	logic swap_fb;
	logic scan_go;
	logic scan_rdy;

	logic [`HUB75_LOG_ROWS-1:0] fb_rd_row;
	logic [`HUB75_LOG_COLS-1:0] fb_rd_col;
	pixel_t                     fb_rd_pixel;

	logic                         shift_go;
	logic                         shift_rdy;
	logic [`HUB75_LOG_ROWS-1:0]   shift_row;
	logic [`HUB75_LOG_PLANES-1:0] shift_plane;
	logic [2:0]                   shift_data;
	logic                         shift_pclk;

	logic                         blank_go;
	logic                         blank_rdy;
	logic [`HUB75_LOG_PLANES-1:0] blank_plane;
	logic                         blank_out;

	logic [`HUB75_LOG_ROWS-1:0] ctrl_addr;
	logic                       ctrl_le;

	pins_t pins_pre;  // core pins before the pad stage

	// swap request held until the scan is idle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			swap_pending <= 1'b0;
		end else begin
			swap_pending <= (swap_pending & ~scan_rdy) | frame_swap;
		end
	end

	assign frame_rdy = ~swap_pending;
	assign swap_fb   = swap_pending & scan_rdy;             // flip between frames
	assign scan_go   = scan_rdy & ~swap_pending & ctrl_run;  // next frame after flip

	assign pins_pre = '{
		addr:  ctrl_addr,
		data:  shift_data,
		clk:   shift_pclk,
		le:    ctrl_le,
		blank: blank_out
	};

	hub75_framebuffer fb_i (
		.clk(clk), .rst(rst),
		.wr_row(wr_row), .wr_col(wr_col), .wr_pixel(wr_pixel), .wr_en(wr_en),  // host
		.rd_row(fb_rd_row), .rd_col(fb_rd_col), .rd_pixel(fb_rd_pixel),         // shifter
		.swap(swap_fb)
	);

	hub75_ctrl ctrl_i (
		.clk(clk), .rst(rst),
		.go(scan_go), .rdy(scan_rdy), .cfg(cfg),
		.shift_go(shift_go), .shift_row(shift_row), .shift_plane(shift_plane),
		.shift_rdy(shift_rdy),
		.blank_go(blank_go), .blank_plane(blank_plane), .blank_rdy(blank_rdy),
		.addr(ctrl_addr), .le(ctrl_le)  // to pads
	);

	hub75_shift shift_i (
		.clk(clk), .rst(rst),
		.go(shift_go), .row(shift_row), .plane(shift_plane), .rdy(shift_rdy),
		.rd_row(fb_rd_row), .rd_col(fb_rd_col), .rd_pixel(fb_rd_pixel),
		.data(shift_data), .pclk(shift_pclk)  // to pads
	);

	hub75_blanking blank_i (
		.clk(clk), .rst(rst),
		.go(blank_go), .plane(blank_plane), .bit_len(cfg.bit_len), .rdy(blank_rdy),
		.blank(blank_out)
	);

	hub75_phy phy_i (
		.clk(clk), .rst(rst),
		.pins_in(pins_pre),
		.pins_out(pins)
	);

endmodule

/* tb/hub75_tb.sv */
// hub75 testbench, host writes and swaps, panel model rebuilds frames from the pins
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_tb;

	import hub75_pkg::*;

	localparam int R          = `HUB75_N_ROWS;
	localparam int C          = `HUB75_N_COLS;
	localparam int P          = `HUB75_N_PLANES;
	localparam int LR         = `HUB75_LOG_ROWS;
	localparam int LC         = `HUB75_LOG_COLS;
	localparam int A_BASE     = 1;               // word 0 holds cfg
	localparam int B_BASE     = A_BASE + R * C;
	localparam int ORDER_BASE = B_BASE + R * C;  // expected latch rows
	localparam int N_WORDS    = ORDER_BASE + R * P;
	localparam int QUIET      = 400;             // idle cycles watched after stop

	logic          clk;
	logic          rst;
	logic [LR-1:0] wr_row;
	logic [LC-1:0] wr_col;
	pixel_t        wr_pixel;
	logic          wr_en;
	logic          frame_swap;
	logic          frame_rdy;
	logic          ctrl_run;
	cfg_t          cfg;
	pins_t         pins;

	logic [31:0] stim [0:N_WORDS-1];
	logic        loaded = 1'b0;

	// panel model
	logic         prev_clk   = 1'b0;
	logic         prev_le    = 1'b0;
	logic         prev_blank = 1'b1;
	logic [C-1:0] sh_r       = '0;  // column shift registers
	logic [C-1:0] sh_g       = '0;
	logic [C-1:0] sh_b       = '0;
	logic [C-1:0] img_r [R][P];     // latched rows per plane
	logic [C-1:0] img_g [R][P];
	logic [C-1:0] img_b [R][P];
	logic [7:0]   low_cnt     = 8'd0;  // saturating blank low count
	int           col_cnt     = 0;
	int           clk_edges   = 0;
	int           latch_total = 0;
	int           lit_total   = 0;     // finished lit intervals
	int           in_frame    = 0;     // latches in current frame
	int           frames_done = 0;
	int           last_plane  = 0;

	hub75_top dut (
		.clk(clk), .rst(rst),
		.wr_row(wr_row), .wr_col(wr_col), .wr_pixel(wr_pixel), .wr_en(wr_en),
		.frame_swap(frame_swap), .frame_rdy(frame_rdy), .ctrl_run(ctrl_run),
		.cfg(cfg), .pins(pins)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns period
	end

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
		if (got !== exp) begin
			report_fail($sformatf("error at %0d ns: %s, got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_addr(input logic [LR-1:0] got, input logic [LR-1:0] exp,
		input string what);
		if (got !== exp) begin
			report_fail($sformatf("error at %0d ns: %s, got %0d expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic check_len(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			report_fail($sformatf("error at %0d ns: %s, got %0d expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			report_fail($sformatf("error at %0d ns: %s, got %b expected %b",
				$time, what, got, exp));
		end
	endtask

	// host pixel straight from the data file
	function automatic pixel_t pixel_of(input int base, input int r, input int c);
		return pixel_t'(stim[base + r * C + c][3*P-1:0]);
	endfunction

	task automatic compare_frame(input int base);
		pixel_t got;
		int     r;
		int     c;
		int     p;
		for (r = 0; r < R; r++) begin
			for (c = 0; c < C; c++) begin
				for (p = 0; p < P; p++) begin
					got.r[p] = img_r[r][p][C-1-c];  // column 0 went in first
					got.g[p] = img_g[r][p][C-1-c];
					got.b[p] = img_b[r][p][C-1-c];
				end
				check_pixel(got, pixel_of(base, r, c),
					$sformatf("frame %0d row %0d col %0d", frames_done, r, c));
			end
		end
	endtask

	task automatic write_frame(input int base);
		int r;
		int c;
		for (r = 0; r < R; r++) begin
			for (c = 0; c < C; c++) begin
				@(posedge clk);
				wr_row   <= LR'(r);
				wr_col   <= LC'(c);
				wr_pixel <= pixel_of(base, r, c);
				wr_en    <= 1'b1;
			end
		end
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic request_swap();
		@(posedge clk);
		frame_swap <= 1'b1;
		@(posedge clk);
		frame_swap <= 1'b0;
		@(posedge clk);
		check_flag(frame_rdy, 1'b0, "frame_rdy after swap request");  // pending now
	endtask

	// pins sampled mid cycle, away from the pad register edge
	always @(negedge clk) begin
		if (pins.clk && !prev_clk) begin  // shift edge
			sh_r = {sh_r[C-2:0], pins.data[2]};
			sh_g = {sh_g[C-2:0], pins.data[1]};
			sh_b = {sh_b[C-2:0], pins.data[0]};
			col_cnt++;
			clk_edges++;
		end
		if (prev_le && !pins.le) begin  // latch closes
			check_len(8'(col_cnt), 8'(C), "columns shifted before latch");
			check_addr(pins.addr, LR'(stim[ORDER_BASE + in_frame]), "latch row order");
			last_plane = in_frame % P;  // planes ascend within a row
			img_r[pins.addr][last_plane] = sh_r;
			img_g[pins.addr][last_plane] = sh_g;
			img_b[pins.addr][last_plane] = sh_b;
			col_cnt = 0;
			latch_total++;
			in_frame++;
			if (in_frame == R * P) begin
				compare_frame(frames_done == 0 ? A_BASE : B_BASE);  // A first, then B
				frames_done++;
				in_frame = 0;
			end
		end
		if (!pins.blank && low_cnt != 8'hff) begin
			low_cnt = low_cnt + 8'd1;
		end
		if (pins.blank && !prev_blank) begin  // lit interval over
			check_len(low_cnt, 8'(int'(cfg.bit_len) * (2 ** last_plane)),
				"lit interval length");
			low_cnt = 8'd0;
			lit_total++;
		end
		prev_clk   = pins.clk;
		prev_le    = pins.le;
		prev_blank = pins.blank;
	end

	// bound from frames, rows, planes and per plane worst case
	initial begin
		cfg_t wd_cfg;
		int   limit;
		wait (loaded);
		wd_cfg = cfg_t'(stim[0]);
		limit  = 4 * R * P * (2 * C + int'(wd_cfg.pre_latch_len) + int'(wd_cfg.latch_len)
			+ int'(wd_cfg.post_latch_len) + int'(wd_cfg.bit_len) * (2 ** P));
		repeat (limit) @(posedge clk);
		report_fail("watchdog timeout, the scan did not reach its end in time");
	end

	initial begin
		int edges_seen;
		int latches_seen;
		rst        = 1'b1;
		wr_row     = '0;
		wr_col     = '0;
		wr_pixel   = '0;
		wr_en      = 1'b0;
		frame_swap = 1'b0;
		ctrl_run   = 1'b0;
		cfg        = '0;
		$readmemh("tb/hub75_input.txt", stim);
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		cfg <= cfg_t'(stim[0]);
		@(posedge clk);
		check_flag(pins.blank, 1'b1, "blank after reset");
		check_flag(pins.le, 1'b0, "le after reset");
		check_flag(frame_rdy, 1'b1, "frame_rdy after reset");
		write_frame(A_BASE);  // back page is 1
		request_swap();
		while (!frame_rdy) @(posedge clk);
		repeat (20) @(posedge clk);
		check_len(8'(clk_edges), 8'd0, "panel clock edges while ctrl_run low");
		ctrl_run <= 1'b1;
		write_frame(B_BASE);  // hidden while A scans
		while (latch_total < 6) @(posedge clk);
		request_swap();
		while (!frame_rdy) @(posedge clk);
		check_len(8'(latch_total), 8'(R * P), "latches when the swap took effect");
		while (latch_total < 2 * R * P + 5) @(posedge clk);  // inside frame 2
		ctrl_run <= 1'b0;
		while (frames_done < 3) @(posedge clk);
		while (lit_total < 3 * R * P) @(posedge clk);  // last plane drains
		edges_seen   = clk_edges;
		latches_seen = latch_total;
		repeat (QUIET) begin
			@(posedge clk);
			check_flag(pins.blank, 1'b1, "blank after scan stopped");
		end
		check_len(8'(clk_edges - edges_seen), 8'd0, "panel clock edges after stop");
		check_len(8'(latch_total - latches_seen), 8'd0, "latches after stop");
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* tb/hub75_input.txt */
// hub75 testbench data, hex words in file order
// word 0 cfg {pre_latch_len, latch_len, post_latch_len, bit_len}, then frame A and
// frame B as 32 pixels {r, g, b} row-major, 8 per line, then 16 expected latch rows
02030205
// frame A, rows 0 to 3
0f0 00f f00 5a3 3c5 c39 9e1 1b7
7d2 2e8 84b b16 6a4 4f9 957 d3c
c2e e65 5b0 0d8 89f f41 1c6 6e3
3a7 7f5 5d1 12c c8a a60 0b9 9e4
// frame B, rows 0 to 3
f0f ff0 0ff a5c c3a 3c6 61e e48
82d d17 7b4 4e9 95b b06 6a8 2c3
3d1 19a a4f f27 760 0be e39 91c
c58 80a a2e ed3 375 59f f46 61b
// latch rows, one line per row, planes 0 to 3
0 0 0 0
1 1 1 1
2 2 2 2
3 3 3 3

/* list.f */
+incdir+include
verilog/hub75_pkg.sv
verilog/hub75_framebuffer.sv
verilog/hub75_ctrl.sv
verilog/hub75_shift.sv
verilog/hub75_blanking.sv
verilog/hub75_phy.sv
verilog/hub75_top.sv
tb/hub75_tb.sv

/* Makefile */
# hub75 panel driver simulation with Verilator

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "make clean  remove the build folder and $(LOG)"
	@echo "make help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --top-module hub75_tb -f list.f -Mdir obj_dir -o hub75_sim
	./obj_dir/hub75_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
